// ==== design/turfio_cout_defs.svh ====
`ifndef TURFIO_COUT_DEFS_SVH
`define TURFIO_COUT_DEFS_SVH

// Number of SURF return lanes on the board
`define COUT_NUM_SURF 7

// Parallel width per sysclk cycle, as fed to a 4:1 DDR serializer
// Bit 0 leaves the pin first
`define COUT_NIB_W 4

// Fixed pattern sent on COUTTIO and all lanes while training
`define COUT_TRAIN_WORD 32'hA55A6996

// Pin polarity swaps, one bit per lane
// Bit i set means lane i has its P/N pair swapped on the board
`define COUT_LANE_INV 7'b0100101

// COUTTIO pair swap
`define COUT_COUTTIO_INV 1'b1

// Transmit clock pair swap
`define COUT_TXCLK_INV 1'b0

`endif

// ==== design/turfio_cout_pkg.sv ====
`include "turfio_cout_defs.svh"

package turfio_cout_pkg;

    // Response word as captured from the response port
    // Seen either as one 32-bit word for capture
    // or as eight nibbles for the per-cycle shift out
    typedef union packed {
        logic [31:0] word;
        // Nibble 0 is the first one sent
        logic [(32/`COUT_NIB_W)-1:0][`COUT_NIB_W-1:0] nib;
    } cout_word_u;

    // All SURF lanes side by side
    // lane[i] is the nibble going out on T_COUT pin i this cycle
    typedef struct packed {
        logic [`COUT_NUM_SURF-1:0][`COUT_NIB_W-1:0] lane;
    } cout_lane_bus_t;

endpackage

// ==== design/cout_response_sequencer.sv ====
`timescale 1ns/1ps
`include "turfio_cout_defs.svh"

// Response sequencer for the COUTTIO return path
// Keeps an 8-cycle phase, captures one word per period
// and hands it out a nibble at a time, low nibble first
module cout_response_sequencer (
    input  logic                   sysclk_i,
    input  logic                   reset_i,
    // Level, selects the training word at capture
    input  logic                   train_i,
    // Pulse marking cycle 0 of the period
    input  logic                   sync_i,
    input  logic [31:0]            response_i,
    // Current low nibble of the hold register
    output logic [`COUT_NIB_W-1:0] train_nib_o,
    // Registered training flag for the lanes
    output logic                   train_mode_o
);

    import turfio_cout_pkg::*;

    // Phase on which the hold register reloads
    localparam logic [2:0] CAPTURE_PHASE = 3'd7;

    // Position within the 8-cycle period
    logic [2:0] phase;

    // Word being shifted out
    cout_word_u hold;

    // Word that would be captured this cycle
    cout_word_u next_word;

    // train_i after one register
    logic train_q;

    // Training pattern wins over the response port
    always_comb begin
        next_word.word = train_i ? `COUT_TRAIN_WORD : response_i;
    end

    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            phase     <= 3'd0;
            hold.word <= 32'd0;
            train_q   <= 1'b0;
        end else begin
            // sync_i marks cycle 0, so the following cycle is phase 1
            if (sync_i) begin
                phase <= 3'd1;
            end else begin
                // Wraps naturally at 8
                phase <= phase + 3'd1;
            end

            // Load at the end of the period, otherwise shift down
            if (phase == CAPTURE_PHASE) begin
                hold <= next_word;
            end else begin
                // Zero fill from the top nibble
                hold.nib <= {{`COUT_NIB_W{1'b0}}, hold.nib[(32/`COUT_NIB_W)-1:1]};
            end

            train_q <= train_i;
        end
    end

    // Nibble 0 of a fresh capture shows up right after the capture edge
    assign train_nib_o = hold.nib[0];

    // Same flag drives every lane
    assign train_mode_o = train_q;

endmodule

// ==== design/cout_lane.sv ====
`timescale 1ns/1ps
`include "turfio_cout_defs.svh"

// One SURF return lane
// Reclocks the lane's SURF nibble, swaps in training data
// when asked, and applies the lane's pin polarity
module cout_lane #(
    // Set when this lane's P/N pair is swapped
    parameter bit LANE_INV = 1'b0
) (
    input  logic                   sysclk_i,
    input  logic                   reset_i,
    input  logic                   train_mode_i,
    input  logic [`COUT_NIB_W-1:0] train_nib_i,
    // This lane's slice of the SURF response bus
    input  logic [`COUT_NIB_W-1:0] surf_nib_i,
    output logic [`COUT_NIB_W-1:0] lane_nib_o
);

    // Polarity bit spread across the nibble
    localparam logic [`COUT_NIB_W-1:0] INV_MASK = {`COUT_NIB_W{LANE_INV}};

    // SURF nibble after the input register
    logic [`COUT_NIB_W-1:0] surf_q;

    // Nibble picked for this cycle, before inversion
    logic [`COUT_NIB_W-1:0] sel_nib;

    // Lane output register, polarity already applied
    logic [`COUT_NIB_W-1:0] lane_q;

    // Training replaces the SURF data entirely
    assign sel_nib = train_mode_i ? train_nib_i : surf_q;

    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            surf_q <= '0;
            // Zero data, seen through the pin swap
            lane_q <= INV_MASK;
        end else begin
            surf_q <= surf_nib_i;
            lane_q <= sel_nib ^ INV_MASK;
        end
    end

    assign lane_nib_o = lane_q;

endmodule

// ==== design/cout_output_stage.sv ====
`timescale 1ns/1ps
`include "turfio_cout_defs.svh"

// Output stage ahead of the serializers
// Retimes the lane bus, lines COUTTIO up with the lanes
// and produces the transmit clock pattern
module cout_output_stage #(
    parameter bit COUTTIO_INV = 1'b0,
    parameter bit TXCLK_INV   = 1'b0
) (
    input  logic                           sysclk_i,
    input  logic                           reset_i,
    input  turfio_cout_pkg::cout_lane_bus_t lanes_i,
    // Low nibble of the sequencer hold register
    input  logic [`COUT_NIB_W-1:0]         train_nib_i,
    output turfio_cout_pkg::cout_lane_bus_t lanes_o,
    output logic [`COUT_NIB_W-1:0]         couttio_o,
    output logic [`COUT_NIB_W-1:0]         txclk_o
);

    import turfio_cout_pkg::*;

    // High then low in each DDR slot pair, slot 0 first
    localparam logic [`COUT_NIB_W-1:0] TXCLK_PATTERN = 4'b0101;

    localparam logic [`COUT_NIB_W-1:0] COUTTIO_MASK = {`COUT_NIB_W{COUTTIO_INV}};
    localparam logic [`COUT_NIB_W-1:0] TXCLK_MASK   = {`COUT_NIB_W{TXCLK_INV}};

    // Per-lane pin swaps on the board
    localparam logic [`COUT_NUM_SURF-1:0] LANE_INV_MASK = `COUT_LANE_INV;

    // Lane bus one cycle behind the lane registers
    cout_lane_bus_t lanes_q;

    // COUTTIO pipeline, two deep to match lane reclock plus this stage
    logic [`COUT_NIB_W-1:0] couttio_q1;
    logic [`COUT_NIB_W-1:0] couttio_q2;

    // Transmit clock word
    logic [`COUT_NIB_W-1:0] txclk_q;

    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            // Zero data on every lane, each through its own pin swap
            for (int i = 0; i < `COUT_NUM_SURF; i++) begin
                lanes_q.lane[i] <= {`COUT_NIB_W{LANE_INV_MASK[i]}};
            end
            couttio_q1 <= COUTTIO_MASK;
            couttio_q2 <= COUTTIO_MASK;
            txclk_q    <= TXCLK_MASK;
        end else begin
            // Pure retiming of lane data
            lanes_q    <= lanes_i;
            // Invert on entry so both stages carry pin polarity
            couttio_q1 <= train_nib_i ^ COUTTIO_MASK;
            couttio_q2 <= couttio_q1;
            // Constant once out of reset
            txclk_q    <= TXCLK_PATTERN ^ TXCLK_MASK;
        end
    end

    assign lanes_o   = lanes_q;
    assign couttio_o = couttio_q2;
    assign txclk_o   = txclk_q;

endmodule

// ==== design/turfio_cout_top.sv ====
`timescale 1ns/1ps
`include "turfio_cout_defs.svh"

// COUT return path top, sysclk domain only
// Sequencer feeds COUTTIO and the training nibble,
// one lane per SURF, then a shared output stage
module turfio_cout_top (
    input  logic                                     sysclk_i,
    input  logic                                     reset_i,
    // Training enable, level
    input  logic                                     train_i,
    // Cycle 0 of the period, one cycle wide
    input  logic                                     sync_i,
    input  logic [31:0]                              response_i,
    // Lane i on bits 4i to 4i+3
    input  logic [`COUT_NUM_SURF*`COUT_NIB_W-1:0]    surf_response_i,
    output turfio_cout_pkg::cout_lane_bus_t          t_cout_o,
    output logic [`COUT_NIB_W-1:0]                   couttio_o,
    output logic [`COUT_NIB_W-1:0]                   txclk_o
);

    import turfio_cout_pkg::*;

    // Per-lane pin swaps
    localparam logic [`COUT_NUM_SURF-1:0] LANE_INV_MASK = `COUT_LANE_INV;

    // Training nibble, shared by all lanes and COUTTIO
    logic [`COUT_NIB_W-1:0] train_nib;

    // Registered training flag
    logic train_mode;

    // Lane register outputs
    cout_lane_bus_t lane_bus;

    cout_response_sequencer u_seq (
        .sysclk_i     (sysclk_i),
        .reset_i      (reset_i),
        .train_i      (train_i),
        .sync_i       (sync_i),
        .response_i   (response_i),
        .train_nib_o  (train_nib),
        .train_mode_o (train_mode)
    );

    // One lane per SURF, each on its own slice of the response bus
    for (genvar i = 0; i < `COUT_NUM_SURF; i++) begin : g_lane
        cout_lane #(
            .LANE_INV (LANE_INV_MASK[i])
        ) u_lane (
            .sysclk_i     (sysclk_i),
            .reset_i      (reset_i),
            .train_mode_i (train_mode),
            .train_nib_i  (train_nib),
            .surf_nib_i   (surf_response_i[i*`COUT_NIB_W +: `COUT_NIB_W]),
            .lane_nib_o   (lane_bus.lane[i])
        );
    end

    cout_output_stage #(
        .COUTTIO_INV (`COUT_COUTTIO_INV),
        .TXCLK_INV   (`COUT_TXCLK_INV)
    ) u_out (
        .sysclk_i    (sysclk_i),
        .reset_i     (reset_i),
        .lanes_i     (lane_bus),
        .train_nib_i (train_nib),
        .lanes_o     (t_cout_o),
        .couttio_o   (couttio_o),
        .txclk_o     (txclk_o)
    );

endmodule

// ==== sim/turfio_cout_props.sv ====
`timescale 1ns/1ps
`include "turfio_cout_defs.svh"

// Concurrent checks on the COUT return path, bound into turfio_cout_top
// Keeps its own view of the 8-cycle period, taken from sync_i alone
module turfio_cout_props (
    input logic                                  sysclk_i,
    input logic                                  reset_i,
    input logic                                  train_i,
    input logic                                  sync_i,
    input logic [31:0]                           response_i,
    input logic [`COUT_NUM_SURF*`COUT_NIB_W-1:0] surf_response_i,
    input turfio_cout_pkg::cout_lane_bus_t       t_cout_o,
    input logic [`COUT_NIB_W-1:0]                couttio_o,
    input logic [`COUT_NIB_W-1:0]                txclk_o
);

    localparam int BUS_W = `COUT_NUM_SURF * `COUT_NIB_W;
    localparam logic [`COUT_NUM_SURF-1:0] LANE_INV = `COUT_LANE_INV;
    localparam logic [`COUT_NIB_W-1:0] COUTTIO_MASK = {`COUT_NIB_W{`COUT_COUTTIO_INV}};
    localparam logic [`COUT_NIB_W-1:0] TXCLK_MASK = {`COUT_NIB_W{`COUT_TXCLK_INV}};
    // High, low, high, low across the DDR slots, slot 0 first
    localparam logic [`COUT_NIB_W-1:0] TXCLK_RUN = 4'b0101 ^ TXCLK_MASK;

    // One expected nibble travelling toward the pins
    typedef struct packed {
        logic                   ok;
        logic                   train;
        logic [`COUT_NIB_W-1:0] nib;
    } exp_slot_t;

    // Read by the testbench for the closing line
    int unsigned fail_count = 0;

    // Edges seen so far, saturating, so $past has history
    int unsigned edges = 0;
    logic warm;

    // Period position as implied by sync_i, valid after the first pulse
    logic [2:0] ph;
    logic ph_ok;

    // Word on the wire and which nibble of it, 8 means none
    logic [31:0] frm_word;
    logic [3:0] frm_k;

    // train_i one edge late, as the lanes see it
    logic train_seen;

    exp_slot_t cur_slot;
    exp_slot_t slot_q1;
    exp_slot_t slot_q2;

    // Same nibble on every lane, each with its own pin swap
    function automatic logic [BUS_W-1:0] lanes_with_polarity(input logic [`COUT_NIB_W-1:0] nib);
        logic [BUS_W-1:0] bus;
        for (int i = 0; i < `COUT_NUM_SURF; i++) begin
            bus[i*`COUT_NIB_W +: `COUT_NIB_W] = nib ^ {`COUT_NIB_W{LANE_INV[i]}};
        end
        return bus;
    endfunction

    assign warm = (edges >= 3);

    always_comb begin
        cur_slot.ok    = (frm_k < 4'd8);
        cur_slot.train = train_seen;
        cur_slot.nib   = frm_word[frm_k[2:0]*`COUT_NIB_W +: `COUT_NIB_W];
    end

    always @(posedge sysclk_i) begin
        if (edges < 3) begin
            edges <= edges + 1;
        end
        if (reset_i) begin
            ph         <= 3'd0;
            ph_ok      <= 1'b0;
            frm_k      <= 4'd8;
            train_seen <= 1'b0;
            slot_q1    <= '0;
            slot_q2    <= '0;
        end else begin
            train_seen <= train_i;
            // Edge with sync high starts phase 1
            if (sync_i) begin
                ph    <= 3'd1;
                ph_ok <= 1'b1;
            end else begin
                ph <= ph + 3'd1;
            end
            // Seventh edge after the sync edge captures a new word
            if (ph_ok && ph == 3'd7) begin
                frm_word <= train_i ? `COUT_TRAIN_WORD : response_i;
                frm_k    <= 4'd0;
            end else if (frm_k != 4'd8) begin
                frm_k <= frm_k + 4'd1;
            end
            // Two more registers between the sequencer nibble and the pins
            slot_q1 <= cur_slot;
            slot_q2 <= slot_q1;
        end
    end

    // From the first reset edge through the first edge after reset
    a_reset_state: assert property (@(posedge sysclk_i)
        (edges >= 1 && $past(reset_i)) || (warm && $past(reset_i, 2)) |->
            t_cout_o.lane == lanes_with_polarity(4'h0) && couttio_o == COUTTIO_MASK)
        else begin
            $error("mismatch at %0t: lanes or couttio_o not at polarity mask in reset", $time);
            fail_count++;
        end

    a_txclk_reset: assert property (@(posedge sysclk_i)
        edges >= 1 && $past(reset_i) |-> txclk_o == TXCLK_MASK)
        else begin
            $error("mismatch at %0t: txclk_o %h in reset", $time, $sampled(txclk_o));
            fail_count++;
        end

    a_txclk_run: assert property (@(posedge sysclk_i)
        warm && !$past(reset_i) |-> txclk_o == TXCLK_RUN)
        else begin
            $error("mismatch at %0t: txclk_o %h, expected %h", $time, $sampled(txclk_o),
                   TXCLK_RUN);
            fail_count++;
        end

    // SURF slice to its lane, two edges after it was sampled
    a_lane_passthru: assert property (@(posedge sysclk_i)
        warm && !$past(reset_i) && !$past(reset_i, 2) && !$past(reset_i, 3)
            && !$past(train_i, 3) |->
            t_cout_o.lane == ($past(surf_response_i, 3) ^ lanes_with_polarity(4'h0)))
        else begin
            $error("mismatch at %0t: t_cout_o does not follow surf_response_i", $time);
            fail_count++;
        end

    a_couttio_frame: assert property (@(posedge sysclk_i)
        warm && slot_q2.ok |-> couttio_o == (slot_q2.nib ^ COUTTIO_MASK))
        else begin
            $error("mismatch at %0t: couttio_o %h, expected %h", $time, $sampled(couttio_o),
                   $sampled(slot_q2.nib) ^ COUTTIO_MASK);
            fail_count++;
        end

    // In training every lane repeats the COUTTIO nibble
    a_lane_train: assert property (@(posedge sysclk_i)
        warm && slot_q2.ok && slot_q2.train |->
            t_cout_o.lane == lanes_with_polarity(slot_q2.nib))
        else begin
            $error("mismatch at %0t: lanes do not carry the training nibble", $time);
            fail_count++;
        end

endmodule

// ==== sim/turfio_cout_tb.sv ====
`timescale 1ns/1ps
`include "turfio_cout_defs.svh"

// Testbench for the COUT return path
// Drives three stimulus blocks, the bound props module checks the outputs
module turfio_cout_tb;

    localparam int RESET_CYCLES     = 16;
    localparam int TRAIN_OFF_CYCLES = 64;
    localparam int RESPONSE_CYCLES  = 160;
    localparam int TRAIN_CYCLES     = 96;
    localparam int DRAIN_CYCLES     = 12;
    localparam int CYCLE_LIMIT      = RESET_CYCLES + TRAIN_OFF_CYCLES + RESPONSE_CYCLES
                                      + TRAIN_CYCLES + DRAIN_CYCLES + 50;

    logic                                  sysclk_i;
    logic                                  reset_i;
    logic                                  train_i;
    logic                                  sync_i;
    logic [31:0]                           response_i;
    logic [`COUT_NUM_SURF*`COUT_NIB_W-1:0] surf_response_i;
    turfio_cout_pkg::cout_lane_bus_t       t_cout_o;
    logic [`COUT_NIB_W-1:0]                couttio_o;
    logic [`COUT_NIB_W-1:0]                txclk_o;

    integer seed;
    int unsigned cycle_cnt;

    turfio_cout_top uut (
        .sysclk_i        (sysclk_i),
        .reset_i         (reset_i),
        .train_i         (train_i),
        .sync_i          (sync_i),
        .response_i      (response_i),
        .surf_response_i (surf_response_i),
        .t_cout_o        (t_cout_o),
        .couttio_o       (couttio_o),
        .txclk_o         (txclk_o)
    );

    bind turfio_cout_top turfio_cout_props u_props (
        .sysclk_i        (sysclk_i),
        .reset_i         (reset_i),
        .train_i         (train_i),
        .sync_i          (sync_i),
        .response_i      (response_i),
        .surf_response_i (surf_response_i),
        .t_cout_o        (t_cout_o),
        .couttio_o       (couttio_o),
        .txclk_o         (txclk_o)
    );

    // 100 ns period
    initial begin
        sysclk_i = 1'b0;
        forever begin
            #50 sysclk_i = ~sysclk_i;
        end
    end

    always @(posedge sysclk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Sync every period start, then one pulse lands mid-period
    function automatic logic response_sync_at(input int i);
        if (i < 80) begin
            return (i % 8) == 0;
        end
        return (i >= 84) && ((i - 84) % 8 == 0);
    endfunction

    // New inputs on the falling edge, random data on both buses
    task automatic apply_cycle(input logic train, input logic sync);
        logic [31:0] rnd;
        @(negedge sysclk_i);
        train_i    = train;
        sync_i     = sync;
        response_i = $random(seed);
        rnd        = $random(seed);
        surf_response_i = rnd[`COUT_NUM_SURF*`COUT_NIB_W-1:0];
    endtask

    initial begin
        seed            = 32'h6e26_658a;
        cycle_cnt       = 0;
        reset_i         = 1'b1;
        train_i         = 1'b0;
        sync_i          = 1'b0;
        response_i      = '0;
        surf_response_i = '0;
        repeat (RESET_CYCLES) @(negedge sysclk_i);
        reset_i = 1'b0;

        // SURF data only, phase free-running
        for (int i = 0; i < TRAIN_OFF_CYCLES; i++) begin
            apply_cycle(1'b0, 1'b0);
        end
        // Responses framed by sync, including a mid-period restart
        for (int i = 0; i < RESPONSE_CYCLES; i++) begin
            apply_cycle(1'b0, response_sync_at(i));
        end
        // Training window, dropped again for the last two periods
        for (int i = 0; i < TRAIN_CYCLES; i++) begin
            apply_cycle(i < TRAIN_CYCLES - 16, (i % 8) == 0);
        end
        // Last frame still has to reach the pins
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            apply_cycle(1'b0, 1'b0);
        end
        @(negedge sysclk_i);

        $display("cycles %0d, assertion failures %0d", cycle_cnt, uut.u_props.fail_count);
        if (uut.u_props.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== turfio_cout.f ====
+incdir+design
design/turfio_cout_pkg.sv
design/cout_response_sequencer.sv
design/cout_lane.sv
design/cout_output_stage.sv
design/turfio_cout_top.sv
sim/turfio_cout_props.sv
sim/turfio_cout_tb.sv
